// ==== draw_screen.f ====
src/draw_pkg.sv
src/raster_box.sv
src/raster_circle.sv
src/raster_rocket.sv
src/screen_clear.sv
src/draw_arbiter.sv
src/draw_screen.sv
verif/draw_screen_assert.sv
verif/tb_draw_screen.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_draw_screen
FILELIST = draw_screen.f

SRCS     = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== verif/tb_draw_screen.sv ====
// tb_draw_screen: clock, reset, random sprite jobs, credit-return model, pixel model, checks
`timescale 1ns/1ns

module tb_draw_screen import draw_pkg::*; ();

  logic    clock = 1'b0;
  logic    reset;
  logic    start;
  logic    game_over;
  logic    req_asteroid;
  logic    req_laser;
  logic    req_rocket;
  sprite_t sprite_asteroid;
  sprite_t sprite_laser;
  sprite_t sprite_rocket;
  logic    pixel_credit;
  logic    pixel_valid;
  pixel_t  pixel;
  logic    done_asteroid;
  logic    done_laser;
  logic    done_rocket;
  logic    done_clear;

  integer seed = 32'h857b4621;
  string  test_name = "reset";
  string  job_names[4] = '{"asteroid", "laser", "rocket", "clear"};

  pixel_t exp_q[$];      // expected writes, all jobs in grant order
  int     job_kind_q[$]; // 0 asteroid, 1 laser, 2 rocket, 3 clear
  int     job_left_q[$]; // writes still owed by each job
  int     credit_due_q[$];
  int     cycles = 0;
  int     cycle_limit = 2000;
  int     total_expected = 0;
  int     writes = 0;
  int     credits_back = 0;
  int     pixel_errors = 0;
  int     done_errors = 0;
  int     other_errors = 0;

  draw_screen dut_i (.*);

  always #20 clock = ~clock;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic sprite_t random_sprite(input int kind);
    sprite_t s;
    int      w;
    int      h;
    w = 2 * dut_i.ASTEROID_RADIUS;
    h = 2 * dut_i.ASTEROID_RADIUS;
    if (kind == 1) begin
      w = dut_i.LASER_W;
      h = dut_i.LASER_H;
    end else if (kind == 2) begin
      w = dut_i.ROCKET_W;
      h = dut_i.ROCKET_H;
    end
    // whole bounding box stays on screen
    s.x = coord_x_t'(rand_below(dut_i.SCREEN_W - w + 1));
    s.y = coord_y_t'(rand_below(dut_i.SCREEN_H - h + 1));
    s.color = color_t'(rand_below(8));
    return s;
  endfunction

  function automatic pixel_t make_pixel(input sprite_t s, input int c, input int r);
    pixel_t p;
    p.x = coord_x_t'(int'(s.x) + c);
    p.y = coord_y_t'(int'(s.y) + r);
    p.color = s.color;
    return p;
  endfunction

  // reference coverage rules, row-major per job
  task automatic expect_job(input int kind, input sprite_t s);
    int  r;
    int  c;
    int  n;
    int  ctr;
    int  rad;
    int  w;
    int  h;
    logic cov;
    n = 0;
    rad = dut_i.ASTEROID_RADIUS;
    case (kind)
      0: begin
        w = 2 * rad;
        h = 2 * rad;
      end
      1: begin
        w = dut_i.LASER_W;
        h = dut_i.LASER_H;
      end
      2: begin
        w = dut_i.ROCKET_W;
        h = dut_i.ROCKET_H;
      end
      default: begin
        w = dut_i.SCREEN_W;
        h = dut_i.SCREEN_H;
      end
    endcase
    for (r = 0; r < h; r++) begin
      for (c = 0; c < w; c++) begin
        cov = 1'b1;
        if (kind == 0) begin
          ctr = rad - 1;
          cov = ((c - ctr) * (c - ctr) + (r - ctr) * (r - ctr)) < rad * rad;
        end else if (kind == 2) begin
          ctr = dut_i.ROCKET_W / 2 - 1;
          if (c == ctr) cov = 1'b1;
          else if (r < dut_i.ROCKET_H - dut_i.ROCKET_FLAME_H) cov = (c - ctr <= r) && (ctr - c <= r);
          else cov = (c >= 2) && (c <= 8); // exhaust
        end
        if (cov) begin
          exp_q.push_back(make_pixel(s, c, r));
          n++;
        end
      end
    end
    job_kind_q.push_back(kind);
    job_left_q.push_back(n);
    total_expected += n;
    cycle_limit = 2 * total_expected + 2000;
  endtask

  task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
    if (act !== exp) begin
      pixel_errors++;
      $display("** Error %s: pixel expected x=%0d y=%0d c=%0d, actual x=%0d y=%0d c=%0d",
               name, exp.x, exp.y, exp.color, act.x, act.y, act.color);
    end
  endtask

  task automatic check_done(input string name, input string which, input logic exp,
                            input logic act);
    if (act !== exp) begin
      done_errors++;
      $display("** Error %s: done_%s expected %b, actual %b", name, which, exp, act);
    end
  endtask

  task automatic request_sprite(input int kind, input sprite_t s);
    @(posedge clock);
    if (kind == 0) begin
      req_asteroid <= 1'b1;
      sprite_asteroid <= s;
    end else if (kind == 1) begin
      req_laser <= 1'b1;
      sprite_laser <= s;
    end else begin
      req_rocket <= 1'b1;
      sprite_rocket <= s;
    end
    @(posedge clock);
    req_asteroid <= 1'b0;
    req_laser <= 1'b0;
    req_rocket <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clock);
    start <= 1'b1;
    @(posedge clock);
    start <= 1'b0;
  endtask

  task automatic wait_idle();
    while (job_kind_q.size() != 0) @(negedge clock);
    repeat (3) @(posedge clock);
  endtask

  always @(posedge clock) begin : cycle_tick
    cycles++;
    if (credit_due_q.size() > 0 && credit_due_q[0] <= cycles) begin
      void'(credit_due_q.pop_front());
      pixel_credit <= 1'b1;
    end else begin
      pixel_credit <= 1'b0;
    end
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d jobs unfinished", cycles, job_kind_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  // outputs sampled mid-cycle, away from the driving edge
  always @(negedge clock) begin : monitor
    logic [3:0] dones;
    logic       front_done;
    int         k;
    if (!reset) begin
      dones = {done_clear, done_rocket, done_laser, done_asteroid};
      if (dones != 4'b0) begin
        front_done = (job_kind_q.size() > 0) && (job_left_q[0] == 0);
        for (k = 0; k < 4; k++) begin
          check_done(test_name, job_names[k], front_done && (job_kind_q[0] == k), dones[k]);
        end
        if (front_done && dones[job_kind_q[0]]) begin
          void'(job_kind_q.pop_front());
          void'(job_left_q.pop_front());
        end
      end
      if (pixel_valid) begin
        writes++;
        if (writes - credits_back > dut_i.FB_CREDITS) begin
          other_errors++;
          $display("** Error %s: writes in flight expected at most %0d, actual %0d",
                   test_name, dut_i.FB_CREDITS, writes - credits_back);
        end
        credit_due_q.push_back(cycles + 1 + rand_below(6));
        if (job_kind_q.size() == 0 || job_left_q[0] == 0) begin
          other_errors++;
          $display("%s: pixel written at x=%0d y=%0d while none was expected",
                   test_name, pixel.x, pixel.y);
        end else begin
          check_pixel(test_name, exp_q.pop_front(), pixel);
          job_left_q[0] = job_left_q[0] - 1;
        end
      end
      if (pixel_credit) credits_back++;
      if (game_over) begin // current job and pending slots are dropped
        exp_q.delete();
        job_kind_q.delete();
        job_left_q.delete();
        expect_job(3, '0);
      end
    end
  end

  initial begin : stimulus
    sprite_t s;
    sprite_t sa;
    sprite_t sl;
    sprite_t sl2;
    sprite_t sr;
    int      i;
    int      kind;
    int      base;
    reset = 1'b1;
    start = 1'b0;
    game_over = 1'b0;
    req_asteroid = 1'b0;
    req_laser = 1'b0;
    req_rocket = 1'b0;
    sprite_asteroid = '0;
    sprite_laser = '0;
    sprite_rocket = '0;
    pixel_credit = 1'b0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    test_name = "laser_box";
    s = random_sprite(1);
    expect_job(1, s);
    request_sprite(1, s);
    pulse_start();
    wait_idle();

    test_name = "asteroid_circle";
    s = random_sprite(0);
    expect_job(0, s);
    request_sprite(0, s);
    wait_idle();

    test_name = "rocket_cone";
    s = random_sprite(2);
    expect_job(2, s);
    request_sprite(2, s);
    wait_idle();

    test_name = "back_pressure";
    for (i = 0; i < 6; i++) begin
      kind = rand_below(3);
      s = random_sprite(kind);
      expect_job(kind, s);
      request_sprite(kind, s);
      wait_idle();
    end

    test_name = "game_over";
    s = random_sprite(2);
    base = writes;
    expect_job(2, s);
    request_sprite(2, s);
    while (writes < base + 4) @(negedge clock);
    @(posedge clock);
    game_over <= 1'b1;
    @(posedge clock);
    game_over <= 1'b0;
    wait_idle();

    // slots latch while waiting for start, laser slot rewritten once
    test_name = "idle_after_clear";
    sa = random_sprite(0);
    sl = random_sprite(1);
    sl2 = random_sprite(1);
    sr = random_sprite(2);
    @(posedge clock);
    req_asteroid <= 1'b1;
    req_laser <= 1'b1;
    req_rocket <= 1'b1;
    sprite_asteroid <= sa;
    sprite_laser <= sl;
    sprite_rocket <= sr;
    @(posedge clock);
    req_asteroid <= 1'b0;
    req_rocket <= 1'b0;
    sprite_laser <= sl2;
    @(posedge clock);
    req_laser <= 1'b0;
    repeat (20) @(posedge clock);

    test_name = "round_robin";
    expect_job(0, sa);
    expect_job(1, sl2);
    expect_job(2, sr);
    pulse_start();
    wait_idle();

    $display("errors: pixel %0d, done %0d, other %0d", pixel_errors, done_errors, other_errors);
    if (pixel_errors + done_errors + other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/draw_screen_assert.sv ====
// credit, go grant and done pulse assertions in a checker bound into draw_arbiter
`timescale 1ns/1ns

module draw_screen_assert #(
  parameter int FB_CREDITS = 4
) (
  input logic                                clock,
  input logic                                reset,
  input logic [$clog2(FB_CREDITS + 1) - 1:0] credits,
  input logic                                pixel_valid,
  input logic                                pixel_credit,
  input logic                                asteroid_go,
  input logic                                laser_go,
  input logic                                rocket_go,
  input logic                                clear_go,
  input logic                                done_asteroid,
  input logic                                done_laser,
  input logic                                done_rocket,
  input logic                                done_clear
);

  int in_flight; // writes whose credit has not come back yet

  always_ff @(posedge clock) begin
    if (reset) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(pixel_valid) - int'(pixel_credit);
    end
  end

  credit_max: assert property (@(posedge clock) disable iff (reset)
    credits <= FB_CREDITS) else $error("credit count above limit");

  valid_needs_credit: assert property (@(posedge clock) disable iff (reset)
    pixel_valid |-> in_flight < FB_CREDITS) else $error("pixel write with no credit left");

  // only one job may start at a time
  single_go: assert property (@(posedge clock) disable iff (reset)
    $onehot0({asteroid_go, laser_go, rocket_go, clear_go})) else $error("two go signals at once");

  done_pulse: assert property (@(posedge clock) disable iff (reset)
    (done_asteroid || done_laser || done_rocket || done_clear) |=>
    !(done_asteroid || done_laser || done_rocket || done_clear))
    else $error("done pulse longer than one cycle");

endmodule

bind draw_arbiter draw_screen_assert #(.FB_CREDITS(FB_CREDITS)) assert_i (
  .clock,
  .reset,
  .credits,
  .pixel_valid,
  .pixel_credit,
  .asteroid_go,
  .laser_go,
  .rocket_go,
  .clear_go,
  .done_asteroid,
  .done_laser,
  .done_rocket,
  .done_clear
);

// ==== src/draw_screen.sv ====
// draw_screen: top level joining the arbiter, three sprite rasterizers and the clear sweep
`timescale 1ns/1ns

module draw_screen import draw_pkg::*; #(
  parameter int SCREEN_W        = 160,
  parameter int SCREEN_H        = 120,
  parameter int FB_CREDITS      = 4,
  parameter int LASER_W         = 1,
  parameter int LASER_H         = 10,
  parameter int ASTEROID_RADIUS = 5,
  parameter int ROCKET_W        = 12,
  parameter int ROCKET_H        = 10,
  parameter int ROCKET_FLAME_H  = 2
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    start,
  input  logic    game_over,
  input  logic    req_asteroid,
  input  logic    req_laser,
  input  logic    req_rocket,
  input  sprite_t sprite_asteroid,
  input  sprite_t sprite_laser,
  input  sprite_t sprite_rocket,
  input  logic    pixel_credit,
  output logic    pixel_valid,
  output pixel_t  pixel,
  output logic    done_asteroid,
  output logic    done_laser,
  output logic    done_rocket,
  output logic    done_clear
);

  logic    a_go, a_adv, a_cov, a_last;
  logic    l_go, l_adv, l_cov, l_last;
  logic    r_go, r_adv, r_cov, r_last;
  logic    c_go, c_adv, c_last;
  sprite_t a_sprite, l_sprite, r_sprite;
  pixel_t  a_cand, l_cand, r_cand, c_cand;

  draw_arbiter #(.FB_CREDITS(FB_CREDITS)) arbiter_i (
    .clock, .reset, .start, .game_over,
    .req_asteroid, .req_laser, .req_rocket,
    .sprite_asteroid, .sprite_laser, .sprite_rocket, .pixel_credit,
    .asteroid_go(a_go), .asteroid_sprite(a_sprite), .asteroid_advance(a_adv),
    .asteroid_cand(a_cand), .asteroid_covered(a_cov), .asteroid_last(a_last),
    .laser_go(l_go), .laser_sprite(l_sprite), .laser_advance(l_adv),
    .laser_cand(l_cand), .laser_covered(l_cov), .laser_last(l_last),
    .rocket_go(r_go), .rocket_sprite(r_sprite), .rocket_advance(r_adv),
    .rocket_cand(r_cand), .rocket_covered(r_cov), .rocket_last(r_last),
    .clear_go(c_go), .clear_advance(c_adv), .clear_cand(c_cand), .clear_last(c_last),
    .pixel_valid, .pixel, .done_asteroid, .done_laser, .done_rocket, .done_clear
  );

  raster_circle #(.RADIUS(ASTEROID_RADIUS)) asteroid_i (
    .clock, .reset, .go(a_go), .sprite(a_sprite), .advance(a_adv),
    .cand(a_cand), .covered(a_cov), .last(a_last)
  );

  raster_box #(.BOX_W(LASER_W), .BOX_H(LASER_H)) laser_i (
    .clock, .reset, .go(l_go), .sprite(l_sprite), .advance(l_adv),
    .cand(l_cand), .covered(l_cov), .last(l_last)
  );

  raster_rocket #(.W(ROCKET_W), .H(ROCKET_H), .FLAME_H(ROCKET_FLAME_H)) rocket_i (
    .clock, .reset, .go(r_go), .sprite(r_sprite), .advance(r_adv),
    .cand(r_cand), .covered(r_cov), .last(r_last)
  );

  screen_clear #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) clear_i (
    .clock, .reset, .go(c_go), .advance(c_adv), .cand(c_cand), .last(c_last)
  );

endmodule

// ==== src/draw_arbiter.sv ====
// draw_arbiter: request slots, round-robin grant, clear priority, credits, pixel mux
`timescale 1ns/1ns

module draw_arbiter import draw_pkg::*; #(
  parameter int FB_CREDITS = 4
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    start,
  input  logic    game_over,
  input  logic    req_asteroid,
  input  logic    req_laser,
  input  logic    req_rocket,
  input  sprite_t sprite_asteroid,
  input  sprite_t sprite_laser,
  input  sprite_t sprite_rocket,
  input  logic    pixel_credit,
  output logic    asteroid_go,
  output sprite_t asteroid_sprite,
  output logic    asteroid_advance,
  input  pixel_t  asteroid_cand,
  input  logic    asteroid_covered,
  input  logic    asteroid_last,
  output logic    laser_go,
  output sprite_t laser_sprite,
  output logic    laser_advance,
  input  pixel_t  laser_cand,
  input  logic    laser_covered,
  input  logic    laser_last,
  output logic    rocket_go,
  output sprite_t rocket_sprite,
  output logic    rocket_advance,
  input  pixel_t  rocket_cand,
  input  logic    rocket_covered,
  input  logic    rocket_last,
  output logic    clear_go,
  output logic    clear_advance,
  input  pixel_t  clear_cand,
  input  logic    clear_last,
  output logic    pixel_valid,
  output pixel_t  pixel,
  output logic    done_asteroid,
  output logic    done_laser,
  output logic    done_rocket,
  output logic    done_clear
);

  localparam int CW = $clog2(FB_CREDITS + 1);

  arb_state_e    state;
  logic [CW-1:0] credits;
  logic          pend_a, pend_l, pend_r;
  sprite_t       slot_a, slot_l, slot_r;
  logic [2:0]    grant; // {rocket, laser, asteroid}
  logic          accept;
  logic          running;
  logic          adv;
  pixel_t        cand_sel;
  logic          covered_sel;
  logic          last_sel;

  assign accept = (state != st_clearing) && !game_over;

  always_ff @(posedge clock) begin
    if (req_asteroid && accept) slot_a <= sprite_asteroid; // newer request overwrites
    if (req_laser && accept) slot_l <= sprite_laser;
    if (req_rocket && accept) slot_r <= sprite_rocket;
  end

  assign asteroid_sprite = slot_a;
  assign laser_sprite    = slot_l;
  assign rocket_sprite   = slot_r;

  always_comb begin
    cand_sel    = clear_cand;
    covered_sel = 1'b1; // every clear pixel is written
    last_sel    = clear_last;
    if (grant[0]) begin
      cand_sel    = asteroid_cand;
      covered_sel = asteroid_covered;
      last_sel    = asteroid_last;
    end else if (grant[1]) begin
      cand_sel    = laser_cand;
      covered_sel = laser_covered;
      last_sel    = laser_last;
    end else if (grant[2]) begin
      cand_sel    = rocket_cand;
      covered_sel = rocket_covered;
      last_sel    = rocket_last;
    end
  end

  // candidate is valid only from the cycle after go
  assign running = (state == st_busy && !(asteroid_go || laser_go || rocket_go)) ||
                   (state == st_clearing && !clear_go);
  assign adv     = running && (!covered_sel || credits != '0);

  assign pixel_valid      = adv && covered_sel;
  assign pixel            = cand_sel;
  assign asteroid_advance = adv && grant[0];
  assign laser_advance    = adv && grant[1];
  assign rocket_advance   = adv && grant[2];
  assign clear_advance    = adv && (state == st_clearing);

  always_ff @(posedge clock) begin
    if (reset) begin
      credits <= CW'(FB_CREDITS);
    end else begin
      credits <= credits - CW'(pixel_valid) + CW'(pixel_credit);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_wait_start;
      pend_a <= 1'b0;
      pend_l <= 1'b0;
      pend_r <= 1'b0;
      grant <= '0;
      asteroid_go <= 1'b0;
      laser_go <= 1'b0;
      rocket_go <= 1'b0;
      clear_go <= 1'b0;
      done_asteroid <= 1'b0;
      done_laser <= 1'b0;
      done_rocket <= 1'b0;
      done_clear <= 1'b0;
    end else begin
      asteroid_go <= 1'b0;
      laser_go <= 1'b0;
      rocket_go <= 1'b0;
      clear_go <= 1'b0;
      // an abandoned job gets no done pulse
      done_asteroid <= asteroid_advance && asteroid_last && !game_over;
      done_laser <= laser_advance && laser_last && !game_over;
      done_rocket <= rocket_advance && rocket_last && !game_over;
      done_clear <= clear_advance && clear_last && !game_over;
      if (game_over) begin
        state <= st_clearing;
        clear_go <= 1'b1;
        pend_a <= 1'b0;
        pend_l <= 1'b0;
        pend_r <= 1'b0;
        grant <= '0;
      end else begin
        if (req_asteroid && accept) pend_a <= 1'b1;
        if (req_laser && accept) pend_l <= 1'b1;
        if (req_rocket && accept) pend_r <= 1'b1;
        case (state)
          st_wait_start: begin
            if (start) state <= st_pick_asteroid;
          end
          st_pick_asteroid: begin
            if (pend_a) begin
              asteroid_go <= 1'b1;
              grant <= 3'b001;
              pend_a <= req_asteroid; // a request this cycle stays pending
              state <= st_busy;
            end else begin
              state <= st_pick_laser;
            end
          end
          st_pick_laser: begin
            if (pend_l) begin
              laser_go <= 1'b1;
              grant <= 3'b010;
              pend_l <= req_laser;
              state <= st_busy;
            end else begin
              state <= st_pick_rocket;
            end
          end
          st_pick_rocket: begin
            if (pend_r) begin
              rocket_go <= 1'b1;
              grant <= 3'b100;
              pend_r <= req_rocket;
              state <= st_busy;
            end else begin
              state <= st_pick_asteroid;
            end
          end
          st_busy: begin
            if (adv && last_sel) begin
              grant <= '0;
              if (grant[0]) state <= st_pick_laser;
              else if (grant[1]) state <= st_pick_rocket;
              else state <= st_pick_asteroid;
            end
          end
          st_clearing: begin
            if (clear_advance && clear_last) state <= st_wait_start;
          end
          default: state <= st_wait_start;
        endcase
      end
    end
  end

endmodule

// ==== src/screen_clear.sv ====
// screen_clear: full-screen row-major sweep in black
`timescale 1ns/1ns

module screen_clear import draw_pkg::*; #(
  parameter int SCREEN_W = 160,
  parameter int SCREEN_H = 120
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   go,
  input  logic   advance,
  output pixel_t cand,
  output logic   last
);

  localparam coord_x_t LAST_COL = coord_x_t'(SCREEN_W - 1);
  localparam coord_y_t LAST_ROW = coord_y_t'(SCREEN_H - 1);

  logic     active;
  coord_x_t col;
  coord_y_t row;

  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
      col <= '0;
      row <= '0;
    end else if (go) begin
      active <= 1'b1; // restarts from the top-left even mid-sweep
      col <= '0;
      row <= '0;
    end else if (active && advance) begin
      if (last) begin
        active <= 1'b0;
      end else if (col == LAST_COL) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  assign last       = (col == LAST_COL) && (row == LAST_ROW);
  assign cand.x     = col;
  assign cand.y     = row;
  assign cand.color = '0;

endmodule

// ==== src/raster_rocket.sv ====
// raster_rocket: box scan with cone, center column and exhaust coverage
`timescale 1ns/1ns

module raster_rocket import draw_pkg::*; #(
  parameter int W       = 12,
  parameter int H       = 10,
  parameter int FLAME_H = 2
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    go,
  input  sprite_t sprite,
  input  logic    advance,
  output pixel_t  cand,
  output logic    covered,
  output logic    last
);

  localparam coord_x_t LAST_COL  = coord_x_t'(W - 1);
  localparam coord_y_t LAST_ROW  = coord_y_t'(H - 1);
  localparam coord_x_t CENTER    = coord_x_t'(W / 2 - 1);
  localparam coord_y_t CONE_ROWS = coord_y_t'(H - FLAME_H);
  localparam coord_x_t FLAME_L   = coord_x_t'(2); // exhaust spans columns 2..8
  localparam coord_x_t FLAME_R   = coord_x_t'(8);

  logic     active;
  coord_x_t col;
  coord_y_t row;
  sprite_t  org;

  logic signed [8:0] dx;
  logic [8:0]        adx;
  logic              in_cone;
  logic              in_flame;

  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
      col <= '0;
      row <= '0;
    end else if (go) begin
      active <= 1'b1;
      col <= '0;
      row <= '0;
    end else if (active && advance) begin
      if (last) begin
        active <= 1'b0;
      end else if (col == LAST_COL) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (go) org <= sprite;
  end

  // cone widens by one column each side per row
  assign dx       = 9'(col) - 9'(CENTER);
  assign adx      = dx[8] ? 9'(-dx) : 9'(dx);
  assign in_cone  = (row < CONE_ROWS) && (adx <= 9'(row));
  assign in_flame = (row >= CONE_ROWS) && (col >= FLAME_L) && (col <= FLAME_R);

  assign last       = (col == LAST_COL) && (row == LAST_ROW);
  assign covered    = active && (in_cone || in_flame || col == CENTER);
  assign cand.x     = org.x + col;
  assign cand.y     = org.y + row;
  assign cand.color = org.color;

endmodule

// ==== src/raster_circle.sv ====
// raster_circle: square scan with squared-distance test for a filled circle
`timescale 1ns/1ns

module raster_circle import draw_pkg::*; #(
  parameter int RADIUS = 5
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    go,
  input  sprite_t sprite,
  input  logic    advance,
  output pixel_t  cand,
  output logic    covered,
  output logic    last
);

  localparam int       CENTER   = RADIUS - 1;
  localparam coord_x_t LAST_COL = coord_x_t'(2 * RADIUS - 1);
  localparam coord_y_t LAST_ROW = coord_y_t'(2 * RADIUS - 1);
  localparam logic signed [17:0] R_SQ = 18'(RADIUS * RADIUS);

  logic     active;
  coord_x_t col;
  coord_y_t row;
  sprite_t  org;

  logic signed [8:0]  dx;
  logic signed [8:0]  dy;
  logic signed [17:0] dist2;

  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
      col <= '0;
      row <= '0;
    end else if (go) begin
      active <= 1'b1;
      col <= '0;
      row <= '0;
    end else if (active && advance) begin
      if (last) begin
        active <= 1'b0;
      end else if (col == LAST_COL) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (go) org <= sprite;
  end

  // distance measured from the center at origin + RADIUS-1
  assign dx    = 9'(col) - 9'(CENTER);
  assign dy    = 9'(row) - 9'(CENTER);
  assign dist2 = dx * dx + dy * dy;

  assign last       = (col == LAST_COL) && (row == LAST_ROW);
  assign covered    = active && (dist2 < R_SQ);
  assign cand.x     = org.x + col;
  assign cand.y     = org.y + row;
  assign cand.color = org.color;

endmodule

// ==== src/raster_box.sv ====
// raster_box: row-major rectangle scan, every pixel covered
`timescale 1ns/1ns

module raster_box import draw_pkg::*; #(
  parameter int BOX_W = 1,
  parameter int BOX_H = 10
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    go,
  input  sprite_t sprite,
  input  logic    advance,
  output pixel_t  cand,
  output logic    covered,
  output logic    last
);

  localparam coord_x_t LAST_COL = coord_x_t'(BOX_W - 1);
  localparam coord_y_t LAST_ROW = coord_y_t'(BOX_H - 1);

  logic     active;
  coord_x_t col; // offset from origin
  coord_y_t row;
  sprite_t  org;

  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
      col <= '0;
      row <= '0;
    end else if (go) begin
      active <= 1'b1;
      col <= '0;
      row <= '0;
    end else if (active && advance) begin
      if (last) begin
        active <= 1'b0;
      end else if (col == LAST_COL) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (go) org <= sprite; // position and color frozen for the whole job
  end

  assign last       = (col == LAST_COL) && (row == LAST_ROW);
  assign covered    = active;
  assign cand.x     = org.x + col;
  assign cand.y     = org.y + row;
  assign cand.color = org.color;

endmodule

// ==== src/draw_pkg.sv ====
// coordinate, color, pixel and sprite types, arbiter state enum
package draw_pkg;

  typedef logic [7:0] coord_x_t; // screen column, 0..159
  typedef logic [6:0] coord_y_t; // screen row, 0..119
  typedef logic [2:0] color_t;

  // one framebuffer write
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    color_t   color;
  } pixel_t;

  // one draw request, origin is the top-left corner of the bounding box
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    color_t   color;
  } sprite_t;

  typedef enum logic [2:0] {
    st_wait_start,
    st_pick_asteroid,
    st_pick_laser,
    st_pick_rocket,
    st_busy,
    st_clearing
  } arb_state_e;

endpackage
